/* fetch_pkg.sv */
// Shared constants and types for the fetch front end
// Memory image is fixed at IMEM_WORDS words, one exception vector only
package fetch_pkg;

	////////////////////
	// Fetch addresses
	////////////////////

	// First fetch after reset
	localparam logic [31:0] RESET_PC   = 32'h0000_0000;
	// Redirect target on flush
	localparam logic [31:0] EXC_VECTOR = 32'h0000_0040;

	////////////////////
	// Memory map
	////////////////////

	localparam int IMEM_WORDS = 24;
	// Word index width into the array
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	// Protected word range, page fault on fetch
	localparam logic [31:0] PROT_BASE  = 32'd16;
	localparam logic [31:0] PROT_LIMIT = 32'd19;
	// Set on an unmapped page
	localparam int UNMAP_BIT  = 31;

	// Response tags, no error / TLB miss / page fault / bus error
	localparam logic [3:0] ITAG_NI = 4'h0;
	localparam logic [3:0] ITAG_TE = 4'hd;
	localparam logic [3:0] ITAG_PE = 4'hc;
	localparam logic [3:0] ITAG_BE = 4'hb;

	////////////////////
	// Instruction encodings
	////////////////////

	typedef enum logic [5:0] {
		OPC_NOP = 6'h05
	} opcode_e;

	// Inserted on flush, rfe and exhausted delay slot
	localparam logic [31:0] NOP_FLUSH = {OPC_NOP, 26'h041_0000};
	// Shown while nothing is fetched
	localparam logic [31:0] NOP_EMPTY = {OPC_NOP, 26'h061_0000};

	// Memory responder state
	typedef enum logic {
		MEM_IDLE,
		MEM_RESP
	} mem_state_e;

	// Fetch error cause, one hot flags decoded from it
	typedef enum logic [1:0] {
		ERR_NONE,
		ERR_TLBMISS,
		ERR_PAGEFAULT,
		ERR_BUSERR
	} fetch_err_e;

endpackage

/* fetch_icpu_if.sv */
// Fetch bus between PC generator, memory and fetch stage
// adr must stay stable until ack or err; exactly one of them per answer
`timescale 1ns/1ns

interface fetch_icpu_if;

	// Fetch address from the PC generator
	logic [31:0] adr;
	// Response from the memory
	logic [31:0] dat;
	logic        ack;
	logic        err;
	// Error tag, valid with err
	logic [3:0]  tag;

	// PC generator side
	modport pcgen (
		output adr,
		input  ack,
		input  err
	);

	// Memory side
	modport mem (
		input  adr,
		output dat,
		output ack,
		output err,
		output tag
	);

	// Fetch stage only observes
	modport fetch (
		input adr,
		input dat,
		input ack,
		input err,
		input tag
	);

endinterface

/* fetch_pc_gen.sv */
// Program counter, always word aligned
// Flush beats branch beats advance; redirects also act under freeze
`timescale 1ns/1ns

module fetch_pc_gen import fetch_pkg::*; (
	input  logic         clk,
	input  logic         rst_i,
	input  logic         freeze_i,
	input  logic         flush_i,
	input  logic         branch_i,
	input  logic [31:0]  branch_target_i,
	fetch_icpu_if.pcgen  icpu
);

	// Current fetch address
	logic [31:0] adr_q;
	logic [31:0] adr_next;
	// Response for adr_q already taken while frozen
	logic        resp_held;
	// Response on the bus this cycle
	logic        resp;
	logic        advance;
	logic        redirect;

	assign resp     = icpu.ack | icpu.err;
	assign redirect = flush_i | branch_i;

	// Move on after a live answer, or once freeze drops
	// with the answer already kept by the fetch stage
	assign advance = !freeze_i & (resp | resp_held);

	////////////////////
	// Next address
	////////////////////

	always_comb begin
		if (flush_i) begin
			adr_next = EXC_VECTOR;
		end else if (branch_i) begin
			// Drop the byte offset of the target
			adr_next = {branch_target_i[31:2], 2'b00};
		end else if (advance) begin
			adr_next = adr_q + 32'd4;
		end else begin
			// Hold for freeze or pending answer
			adr_next = adr_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			adr_q <= RESET_PC;
		end else begin
			adr_q <= adr_next;
		end
	end

	////////////////////
	// Answer seen under freeze
	////////////////////

	// Repeated answers for a held address are not counted again
	always_ff @(posedge clk) begin
		if (rst_i) begin
			resp_held <= 1'b0;
		end else if (redirect | advance) begin
			resp_held <= 1'b0;
		end else if (resp & freeze_i) begin
			resp_held <= 1'b1;
		end
	end

	assign icpu.adr = adr_q;

endmodule

/* fetch_imem.sv */
// Instruction memory, one wait cycle, image from fetch_prog.hex
// A changed address during a response is resampled, not answered
`timescale 1ns/1ns

module fetch_imem import fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	fetch_icpu_if.mem  icpu
);

	logic [31:0] mem [IMEM_WORDS];

	mem_state_e  state_q;
	// Address under service
	logic [31:0] adr_q;
	// Word address of adr_q, zero extended
	logic [31:0] word_adr;
	logic        adr_hit;
	logic        respond;
	logic        is_te;
	logic        is_pe;
	logic        is_be;
	logic        is_err;

	initial begin
		$readmemh("fetch_prog.hex", mem);
	end

	////////////////////
	// Request tracking
	////////////////////

	// Bus still shows the address being answered
	assign adr_hit = (icpu.adr == adr_q);
	assign respond = (state_q == MEM_RESP) & adr_hit;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= MEM_IDLE;
		end else begin
			case (state_q)
				MEM_IDLE: state_q <= MEM_RESP;
				// Stay on a redirect, answer the new address next
				MEM_RESP: begin
					if (adr_hit) begin
						state_q <= MEM_IDLE;
					end
				end
				default: state_q <= MEM_IDLE;
			endcase
		end
	end

	// Sample in idle, resample when the address moved
	always_ff @(posedge clk) begin
		if ((state_q == MEM_IDLE) || !adr_hit) begin
			adr_q <= icpu.adr;
		end
	end

	////////////////////
	// Address checks
	////////////////////

	assign word_adr = {2'b00, adr_q[31:2]};

	// Unmapped page
	assign is_te  = adr_q[UNMAP_BIT];
	// Protected words
	assign is_pe  = (word_adr >= PROT_BASE) && (word_adr <= PROT_LIMIT);
	// Past the end of the image
	assign is_be  = (word_adr >= IMEM_WORDS);
	assign is_err = is_te | is_pe | is_be;

	assign icpu.ack = respond & !is_err;
	assign icpu.err = respond & is_err;

	// Tag by priority, TLB miss first
	always_comb begin
		if (!icpu.err) begin
			icpu.tag = ITAG_NI;
		end else if (is_te) begin
			icpu.tag = ITAG_TE;
		end else if (is_pe) begin
			icpu.tag = ITAG_PE;
		end else begin
			icpu.tag = ITAG_BE;
		end
	end

	// Index is in range whenever ack is high
	assign icpu.dat = icpu.ack ? mem[adr_q[IMEM_AW+1:2]] : 32'h0000_0000;

endmodule

/* fetch_if_stage.sv */
// Fetch stage, keeps first answer under freeze until freeze drops
// Flush starts bypass until the next answer; flags masked by no_more_dslot
`timescale 1ns/1ns

module fetch_if_stage import fetch_pkg::*; (
	input  logic         clk,
	input  logic         rst_i,
	input  logic         freeze_i,
	input  logic         flush_i,
	input  logic         no_more_dslot_i,
	input  logic         rfe_i,
	fetch_icpu_if.fetch  icpu,
	output logic [31:0]  insn_o,
	output logic [31:0]  pc_o,
	output logic         stall_o,
	output logic         saving_o,
	output logic         except_itlbmiss_o,
	output logic         except_immufault_o,
	output logic         except_ibuserr_o
);

	logic        resp;
	logic        save_insn;
	logic        bypass;
	logic        bypass_q;
	logic        saved;
	logic [31:0] insn_saved;
	logic [31:0] addr_saved;
	fetch_err_e  err_saved;
	// Cause of the live answer
	fetch_err_e  err_cause;
	// Cause shown at the outputs
	fetch_err_e  err_sel;

	assign resp = icpu.ack | icpu.err;

	// First answer under freeze only
	assign save_insn = resp & freeze_i & !saved;
	assign saving_o  = !flush_i & save_insn;

	////////////////////
	// Bypass after flush
	////////////////////

	// Ends on the first answer after the flush edge
	assign bypass = flush_i | (bypass_q & !resp);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			bypass_q <= 1'b0;
		end else begin
			bypass_q <= bypass;
		end
	end

	// Tag decode
	always_comb begin
		if (!icpu.err) begin
			err_cause = ERR_NONE;
		end else begin
			case (icpu.tag)
				ITAG_TE: err_cause = ERR_TLBMISS;
				ITAG_PE: err_cause = ERR_PAGEFAULT;
				ITAG_BE: err_cause = ERR_BUSERR;
				default: err_cause = ERR_NONE;
			endcase
		end
	end

	////////////////////
	// Saved answer
	////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			saved <= 1'b0;
		end else if (flush_i) begin
			saved <= 1'b0;
		end else if (save_insn) begin
			saved <= 1'b1;
		end else if (!freeze_i) begin
			saved <= 1'b0;
		end
	end

	// Only read while saved is set
	always_ff @(posedge clk) begin
		if (save_insn) begin
			// Errored fetch keeps a NOP in place of data
			insn_saved <= icpu.err ? NOP_FLUSH : icpu.dat;
			addr_saved <= {icpu.adr[31:2], 2'b00};
			err_saved  <= err_cause;
		end
	end

	////////////////////
	// Outputs
	////////////////////

	always_comb begin
		if (no_more_dslot_i | rfe_i | bypass) begin
			insn_o = NOP_FLUSH;
		end else if (saved) begin
			insn_o = insn_saved;
		end else if (icpu.ack) begin
			insn_o = icpu.dat;
		end else begin
			insn_o = NOP_EMPTY;
		end
	end

	assign pc_o    = saved ? addr_saved : {icpu.adr[31:2], 2'b00};
	assign stall_o = !resp & !saved;

	assign err_sel = saved ? err_saved : err_cause;

	// No exception from a fetch that may not issue
	assign except_itlbmiss_o  = !no_more_dslot_i & (err_sel == ERR_TLBMISS);
	assign except_immufault_o = !no_more_dslot_i & (err_sel == ERR_PAGEFAULT);
	assign except_ibuserr_o   = !no_more_dslot_i & (err_sel == ERR_BUSERR);

endmodule

/* fetch_top.sv */
// Fetch front end, PC generator, memory and fetch stage
// Outputs come straight from the fetch stage, no extra register
`timescale 1ns/1ns

module fetch_top (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        freeze_i,
	input  logic        flush_i,
	input  logic        branch_i,
	input  logic [31:0] branch_target_i,
	input  logic        no_more_dslot_i,
	input  logic        rfe_i,
	output logic [31:0] insn_o,
	output logic [31:0] pc_o,
	output logic        stall_o,
	output logic        saving_o,
	output logic        except_itlbmiss_o,
	output logic        except_immufault_o,
	output logic        except_ibuserr_o
);

	// Fetch bus
	fetch_icpu_if icpu_bus ();

	// Address source
	fetch_pc_gen pc_gen_inst (
		.clk             (clk),
		.rst_i           (rst_i),
		.freeze_i        (freeze_i),
		.flush_i         (flush_i),
		.branch_i        (branch_i),
		.branch_target_i (branch_target_i),
		.icpu            (icpu_bus.pcgen)
	);

	// Responder
	fetch_imem imem_inst (
		.clk   (clk),
		.rst_i (rst_i),
		.icpu  (icpu_bus.mem)
	);

	// Pipeline side
	fetch_if_stage if_stage_inst (
		.clk                (clk),
		.rst_i              (rst_i),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.icpu               (icpu_bus.fetch),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.stall_o            (stall_o),
		.saving_o           (saving_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

/* tb_fetch.sv */
// Directed testbench for the fetch front end
// Reads fetch_prog.hex from the working directory as reference image
`timescale 1ns/1ns

module tb_fetch import fetch_pkg::*; ();

	logic        clk;
	logic        rst_i;
	logic        freeze_i;
	logic        flush_i;
	logic        branch_i;
	logic [31:0] branch_target_i;
	logic        no_more_dslot_i;
	logic        rfe_i;
	logic [31:0] insn_o;
	logic [31:0] pc_o;
	logic        stall_o;
	logic        saving_o;
	logic        except_itlbmiss_o;
	logic        except_immufault_o;
	logic        except_ibuserr_o;

	// Reference image
	logic [31:0] ref_mem [IMEM_WORDS];
	int          errors;
	int          tests_passed;
	int          tests_failed;

	fetch_top fetch_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	// Expected cause by the memory map with TLB miss first
	function automatic fetch_err_e expected_cause(input logic [31:0] adr);
		logic [31:0] word;
		word = adr >> 2;
		if (adr[UNMAP_BIT]) begin
			return ERR_TLBMISS;
		end else if (word >= PROT_BASE && word <= PROT_LIMIT) begin
			return ERR_PAGEFAULT;
		end else if (word >= IMEM_WORDS) begin
			return ERR_BUSERR;
		end
		return ERR_NONE;
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Live answer at adr against the image or the error flag
	task automatic check_fetch(input logic [31:0] adr);
		fetch_err_e cause;
		cause = expected_cause(adr);
		compare("pc_o", pc_o, adr);
		if (cause == ERR_NONE) begin
			compare("insn_o", insn_o, ref_mem[adr >> 2]);
		end else begin
			compare("insn_o", insn_o, NOP_EMPTY);
		end
		compare("except_itlbmiss_o", except_itlbmiss_o, cause == ERR_TLBMISS);
		compare("except_immufault_o", except_immufault_o, cause == ERR_PAGEFAULT);
		compare("except_ibuserr_o", except_ibuserr_o, cause == ERR_BUSERR);
	endtask

	// Closed delay slot shows the NOP and no exception flag
	task automatic verify_dslot_mask();
		compare("insn_o", insn_o, NOP_FLUSH);
		compare("except_itlbmiss_o", except_itlbmiss_o, 1'b0);
		compare("except_immufault_o", except_immufault_o, 1'b0);
		compare("except_ibuserr_o", except_ibuserr_o, 1'b0);
	endtask

	// Next cycle without stall as seen at the falling edge
	task automatic wait_response();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (stall_o && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (stall_o) begin
			$display("timeout at %0t: no fetch response within 20 cycles", $time);
			errors++;
		end
	endtask

	// One cycle branch pulse that returns on the edge dropping it
	task automatic branch_to(input logic [31:0] target);
		@(posedge clk);
		branch_i        <= 1'b1;
		branch_target_i <= target;
		@(posedge clk);
		branch_i        <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		if (errors == 0) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: failed with %0d errors", name, errors);
			tests_failed++;
		end
		errors = 0;
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_sequential();
		// Idle outputs right after reset
		@(negedge clk);
		compare("stall_o", stall_o, 1'b1);
		compare("insn_o", insn_o, NOP_EMPTY);
		compare("pc_o", pc_o, RESET_PC);
		compare("except_itlbmiss_o", except_itlbmiss_o, 1'b0);
		compare("except_immufault_o", except_immufault_o, 1'b0);
		compare("except_ibuserr_o", except_ibuserr_o, 1'b0);
		for (int i = 0; i < 8; i++) begin
			wait_response();
			check_fetch(RESET_PC + 32'(4 * i));
			// Memory answers every second cycle
			@(negedge clk);
			compare("stall_o", stall_o, 1'b1);
		end
		finish_test("sequential fetch");
	endtask

	task automatic test_freeze();
		int saves;
		saves = 0;
		branch_to(32'h0000_0010);
		wait_response();
		check_fetch(32'h0000_0010);
		@(posedge clk);
		freeze_i <= 1'b1;
		// Answer for 0x14 arrives frozen and is kept
		repeat (8) begin
			@(negedge clk);
			if (saving_o) begin
				saves++;
			end
			if (saves > 0) begin
				check_fetch(32'h0000_0014);
				compare("stall_o", stall_o, 1'b0);
			end
		end
		compare("saving_o pulses", saves, 1);
		@(posedge clk);
		freeze_i <= 1'b0;
		// Kept word issues once before the next address
		wait_response();
		check_fetch(32'h0000_0014);
		wait_response();
		check_fetch(32'h0000_0018);
		finish_test("freeze hold");
	endtask

	task automatic test_branch();
		branch_to(32'h0000_0054);
		wait_response();
		check_fetch(32'h0000_0054);
		wait_response();
		check_fetch(32'h0000_0058);
		branch_to(32'h0000_0008);
		wait_response();
		check_fetch(32'h0000_0008);
		finish_test("branch redirect");
	endtask

	task automatic test_errors();
		branch_to(32'h0000_0040);
		wait_response();
		check_fetch(32'h0000_0040);
		branch_to(32'h0000_0060);
		wait_response();
		check_fetch(32'h0000_0060);
		branch_to(32'h8000_0000);
		wait_response();
		check_fetch(32'h8000_0000);
		// Page fault kept under freeze
		branch_to(32'h0000_0044);
		freeze_i <= 1'b1;
		wait_response();
		repeat (4) begin
			compare("pc_o", pc_o, 32'h0000_0044);
			compare("except_immufault_o", except_immufault_o, 1'b1);
			compare("stall_o", stall_o, 1'b0);
			@(negedge clk);
		end
		@(posedge clk);
		no_more_dslot_i <= 1'b1;
		@(negedge clk);
		verify_dslot_mask();
		// Freeze drops while the slot stays closed
		@(posedge clk);
		freeze_i <= 1'b0;
		// Kept fault issues first
		wait_response();
		// Live page fault at the next word is masked too
		wait_response();
		compare("pc_o", pc_o, 32'h0000_0048);
		verify_dslot_mask();
		@(posedge clk);
		no_more_dslot_i <= 1'b0;
		finish_test("error tags");
	endtask

	task automatic test_flush_rfe();
		int cycles;
		int answers;
		cycles  = 0;
		answers = 0;
		branch_to(32'h0000_0000);
		wait_response();
		@(posedge clk);
		flush_i <= 1'b1;
		@(negedge clk);
		compare("insn_o", insn_o, NOP_FLUSH);
		@(posedge clk);
		flush_i <= 1'b0;
		// NOP until the answer at the vector
		@(negedge clk);
		while (stall_o && cycles < 20) begin
			compare("insn_o", insn_o, NOP_FLUSH);
			@(negedge clk);
			cycles++;
		end
		if (stall_o) begin
			$display("timeout at %0t: no answer at the exception vector", $time);
			errors++;
		end else begin
			check_fetch(EXC_VECTOR);
		end
		branch_to(32'h0000_0000);
		rfe_i <= 1'b1;
		repeat (6) begin
			@(negedge clk);
			compare("insn_o", insn_o, NOP_FLUSH);
			if (!stall_o) begin
				answers++;
			end
		end
		if (answers == 0) begin
			$display("no fetch answer arrived while rfe was high");
			errors++;
		end
		@(posedge clk);
		rfe_i <= 1'b0;
		finish_test("flush and rfe");
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_i           = 1'b1;
		freeze_i        = 1'b0;
		flush_i         = 1'b0;
		branch_i        = 1'b0;
		branch_target_i = 32'h0000_0000;
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b0;
		errors          = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		$readmemh("fetch_prog.hex", ref_mem);
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		test_sequential();
		test_freeze();
		test_branch();
		test_errors();
		test_flush_rfe();
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* fetch_prog.hex */
// One 32-bit instruction word per line, word address 0 to 23
// Words 16 to 19 sit in the protected range and answer with a page fault
9c200001
9c400002
9c600003
e0811000
e0a21800
d4010800
84610000
bc030005
10000004
9c630001
e1031000
18800000
a8840100
d4041800
44004800
9c210004
deadc0de
badf00d1
c001d00d
0badcafe
9ca00010
e0c52800
07fffffe
9c210008

/* build.f */
fetch_pkg.sv
fetch_icpu_if.sv
fetch_pc_gen.sv
fetch_imem.sv
fetch_if_stage.sv
fetch_top.sv
tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - fetch_pkg.sv
  - fetch_icpu_if.sv
  - fetch_pc_gen.sv
  - fetch_imem.sv
  - fetch_if_stage.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch.sv
